/* src.f */
src/rlwe_pkg.sv
src/rlwe_butterfly_pipe.sv
src/rlwe_mem_port.sv
src/rlwe_block_seq.sv
src/rlwe_exu_top.sv
sim/rlwe_exu_sva.sv
sim/tb_clk_gen.sv
sim/tb_rlwe_exu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the RLWE execution unit testbench with Verilator, run it, then grep the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_rlwe_exu -f src.f -o sim_rlwe_exu \
    && ./obj_dir/sim_rlwe_exu | tee sim.log \
    || { echo "Verilator build or simulation run failed"; exit 1; }

grep -q "^TESTS PASSED$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* sim/tb_rlwe_exu.sv */
/*
 * RLWE execution unit testbench
 * Memory model with random wait states, command stimulus,
 * lane-pair butterfly reference model, memory checks and report
 */

`timescale 1ns/100ps
`default_nettype none

module tb_rlwe_exu
    import rlwe_pkg::*;
();

    localparam int    MEM_WORDS      = 2**ADDR_W;
    localparam int    TIMEOUT_CYCLES = 8000;     // 4 cmds x 64 vectors x ~20 cycles + margin
    localparam int    HALF_Q         = (RLWE_Q + 1) / 2;  // Inverse of 2 mod Q
    localparam addr_t BLK_A          = 16'h0100;  // Random source blocks A and D
    localparam addr_t BLK_B          = 16'h0240;
    localparam addr_t BLK_C          = 16'h0380;
    localparam addr_t BLK_D          = 16'hf000;
    localparam addr_t BLK_E          = 16'h7fc0;
    localparam addr_t BLK_F          = 16'hffc0;  // Ends on the last address

    logic     clk;
    logic     rst_n;
    logic     cmd_req;
    rlwe_op_e cmd_op;
    addr_t    cmd_src;
    addr_t    cmd_dst;
    logic     cmd_ack;
    logic     busy;
    logic     mem_req;
    logic     mem_we;
    addr_t    mem_addr;
    vec_t     mem_wdata;
    logic     mem_ack;
    vec_t     mem_rdata;

    vec_t mem [MEM_WORDS];                        // Memory model contents
    vec_t exp_mem [MEM_WORDS];                    // Expected contents
    int   wr_cmd [MEM_WORDS];                     // Command that last wrote each word
    int   cmd_num      = 0;
    int   total_writes = 0;
    int   mem_faults   = 0;                       // Counted by the memory process
    int   errors       = 0;                       // Counted by the stimulus process
    int   tests_run    = 0;
    int   cycles       = 0;

    tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    rlwe_exu_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_req   (cmd_req),
        .cmd_op    (cmd_op),
        .cmd_src   (cmd_src),
        .cmd_dst   (cmd_dst),
        .cmd_ack   (cmd_ack),
        .busy      (busy),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    // ------------------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------------------
    function automatic vec_t fill_word(input addr_t a);
        return {~a, a ^ 16'ha5a5, a + 16'h3c3c, a};  // Background pattern unique per address
    endfunction

    function automatic vec_t rand_vec();
        vec_t v;
        for (int l = 0; l < LANE_COUNT; l++) begin
            v[l*LANE_W +: LANE_W] = lane_t'($urandom_range(RLWE_Q - 1, 0));
        end
        return v;
    endfunction

    function automatic vec_t ref_xform(input vec_t v, input bit inverse);
        vec_t r;
        int   a;
        int   b;
        int   x;
        int   y;
        for (int p = 0; p < LANE_COUNT; p += 2) begin
            a = int'(v[p*LANE_W +: LANE_W]);
            b = int'(v[(p+1)*LANE_W +: LANE_W]);
            x = (a + b) % RLWE_Q;
            y = (a - b + RLWE_Q) % RLWE_Q;
            if (inverse) begin
                x = (x * HALF_Q) % RLWE_Q;        // Halving as a multiply by 1/2
                y = (y * HALF_Q) % RLWE_Q;
            end
            r[p*LANE_W +: LANE_W]     = lane_t'(x);
            r[(p+1)*LANE_W +: LANE_W] = lane_t'(y);
        end
        return r;
    endfunction

    function automatic int fault_count();
        return errors + mem_faults + i_dut.i_sva.sva_errors;
    endfunction

    // ------------------------------------------------------------------------
    // Memory model with random 0..3 wait cycles per request
    // ------------------------------------------------------------------------
    task automatic serve_access();
        int off;
        if (mem_we) begin
            off = int'(addr_t'(mem_addr - cmd_dst));
            assert (off < BLOCK_VECTORS) else begin
                mem_faults++;
                $display("[%0t] write to %h outside the destination block", $time, mem_addr);
            end
            assert (wr_cmd[mem_addr] != cmd_num) else begin
                mem_faults++;
                $display("[%0t] destination word %h written twice", $time, mem_addr);
            end
            wr_cmd[mem_addr] = cmd_num;
            total_writes++;
            mem[mem_addr] = mem_wdata;
        end else begin
            off = int'(addr_t'(mem_addr - cmd_src));
            assert (off < BLOCK_VECTORS) else begin
                mem_faults++;
                $display("[%0t] read from %h outside the source block", $time, mem_addr);
            end
            mem_rdata <= mem[mem_addr];
        end
    endtask

    initial begin
        int wait_left;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        void'($urandom(9));
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[addr_t'(a)] = fill_word(addr_t'(a));
        end
        for (int i = 0; i < BLOCK_VECTORS; i++) begin
            mem[BLK_A + addr_t'(i)] = rand_vec();  // Lanes below Q
            mem[BLK_D + addr_t'(i)] = rand_vec();
        end
        wait_left = int'($urandom_range(3, 0));
        forever begin
            @(posedge clk);
            if (mem_ack) begin
                if (!mem_req) begin
                    mem_ack <= 1'b0;              // Return to idle
                end
            end else if (mem_req) begin
                if (wait_left == 0) begin
                    mem_ack <= 1'b1;
                    serve_access();
                    wait_left = int'($urandom_range(3, 0));
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Command stimulus and checks
    // ------------------------------------------------------------------------
    task automatic compare_memory();
        for (int a = 0; a < MEM_WORDS; a++) begin
            assert (mem[addr_t'(a)] === exp_mem[addr_t'(a)]) else begin
                errors++;
                $display("MISMATCH t=%0t mem[%h] expected %h actual %h", $time,
                         addr_t'(a), exp_mem[addr_t'(a)], mem[addr_t'(a)]);
            end
        end
    endtask

    task automatic check_round_trip(input addr_t orig, input addr_t back);
        for (int i = 0; i < BLOCK_VECTORS; i++) begin
            assert (mem[back + addr_t'(i)] === mem[orig + addr_t'(i)]) else begin
                errors++;
                $display("MISMATCH t=%0t mem[%h] expected %h actual %h", $time,
                         back + addr_t'(i), mem[orig + addr_t'(i)], mem[back + addr_t'(i)]);
            end
        end
    endtask

    task automatic run_cmd(input rlwe_op_e op, input addr_t src, input addr_t dst,
                           input int hold);
        int start_writes;
        cmd_num++;
        start_writes = total_writes;
        @(posedge clk);
        cmd_op  <= op;
        cmd_src <= src;
        cmd_dst <= dst;
        cmd_req <= 1'b1;
        do @(posedge clk); while (!cmd_ack);
        assert (total_writes - start_writes == BLOCK_VECTORS) else begin
            errors++;
            $display("MISMATCH t=%0t dest_writes expected %0d actual %0d", $time,
                     BLOCK_VECTORS, total_writes - start_writes);
        end
        repeat (hold) @(posedge clk);             // Host slow to release
        cmd_req <= 1'b0;
        do @(posedge clk); while (cmd_ack);
        for (int i = 0; i < BLOCK_VECTORS; i++) begin
            exp_mem[dst + addr_t'(i)] = ref_xform(exp_mem[src + addr_t'(i)], op == RLWE_INV);
        end
        compare_memory();
    endtask

    task automatic report_test(input string name, input int faults_before);
        tests_run++;
        if (fault_count() == faults_before) begin
            $display("[%0t] %s: ok", $time, name);
        end else begin
            $display("[%0t] %s: %0d failed checks", $time, name, fault_count() - faults_before);
        end
    endtask

    initial begin
        int f0;
        cmd_req = 1'b0;
        cmd_op  = RLWE_FWD;
        cmd_src = '0;
        cmd_dst = '0;
        wait (rst_n);
        @(posedge clk);

        f0 = fault_count();
        assert (cmd_ack === 1'b0) else begin
            errors++;
            $display("MISMATCH t=%0t cmd_ack expected 0 actual %b", $time, cmd_ack);
        end
        assert (busy === 1'b0) else begin
            errors++;
            $display("MISMATCH t=%0t busy expected 0 actual %b", $time, busy);
        end
        report_test("reset state", f0);
        exp_mem = mem;

        f0 = fault_count();
        run_cmd(RLWE_FWD, BLK_A, BLK_B, 0);
        report_test("forward transform", f0);

        f0 = fault_count();
        run_cmd(RLWE_INV, BLK_B, BLK_C, 1);
        check_round_trip(BLK_A, BLK_C);
        report_test("round trip", f0);

        f0 = fault_count();
        run_cmd(RLWE_FWD, BLK_D, BLK_E, 6);       // Ack must hold while req stays up
        report_test("command handshake", f0);

        f0 = fault_count();
        run_cmd(RLWE_INV, BLK_E, BLK_F, 2);
        check_round_trip(BLK_D, BLK_F);
        report_test("address discipline", f0);

        $display("Summary: %0d tests run, %0d failed checks", tests_run, fault_count());
        if (fault_count() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a command never completed", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

endmodule : tb_rlwe_exu

`default_nettype wire

/* sim/tb_clk_gen.sv */
/*
 * Testbench clock, 8 ns period, and active-low reset held for 8 cycles
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                    // 125 MHz
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;                            // Released on a rising edge
    end

endmodule : tb_clk_gen

`default_nettype wire

/* sim/rlwe_exu_sva.sv */
/*
 * Concurrent checks on the command and data-memory four-phase handshakes,
 * bound into the execution unit top level
 */

`timescale 1ns/100ps
`default_nettype none

module rlwe_exu_sva
    import rlwe_pkg::*;
(
    input logic  clk,
    input logic  rst_n,
    input logic  cmd_req,
    input logic  cmd_ack,
    input logic  busy,
    input logic  mem_req,
    input logic  mem_we,
    input addr_t mem_addr,
    input vec_t  mem_wdata,
    input logic  mem_ack
);

    int sva_errors = 0;                           // Failed assertions so far

    // ------------------------------------------------------------------------
    // Memory port
    // ------------------------------------------------------------------------
    mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req)
        else begin
            sva_errors++;
            $error("mem_req dropped before mem_ack");
        end

    mem_fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_we)
                                      && $stable(mem_wdata))
        else begin
            sva_errors++;
            $error("mem_addr, mem_we or mem_wdata changed during a request");
        end

    mem_req_released: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && mem_ack |=> !mem_req)
        else begin
            sva_errors++;
            $error("mem_req still high the cycle after mem_ack");
        end

    mem_req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> !mem_ack)
        else begin
            sva_errors++;
            $error("new mem_req raised while mem_ack still high");
        end

    // ------------------------------------------------------------------------
    // Command port
    // ------------------------------------------------------------------------
    cmd_ack_only_on_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> cmd_req)
        else begin
            sva_errors++;
            $error("cmd_ack raised without a pending cmd_req");
        end

    cmd_ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_ack && cmd_req |=> cmd_ack)
        else begin
            sva_errors++;
            $error("cmd_ack dropped while cmd_req still high");
        end

    cmd_ack_closed: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_ack && !cmd_req |=> !cmd_ack)
        else begin
            sva_errors++;
            $error("cmd_ack not lowered after cmd_req fell");
        end

    busy_during_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_req && $past(cmd_req) && !cmd_ack |-> busy)
        else begin
            sva_errors++;
            $error("busy low while a command is in progress");
        end

endmodule : rlwe_exu_sva

bind rlwe_exu_top rlwe_exu_sva i_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .busy      (busy),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack)
);

`default_nettype wire

/* src/rlwe_exu_top.sv */
/*
 * RLWE execution unit top level
 * Block sequencer, data-memory port and lane-pair butterfly stage
 */

`timescale 1ns/100ps
`default_nettype none

module rlwe_exu_top
    import rlwe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    // Command port, four-phase
    input  logic     cmd_req,
    input  rlwe_op_e cmd_op,                    // Forward or inverse
    input  addr_t    cmd_src,                   // Source block base
    input  addr_t    cmd_dst,                   // Destination block base
    output logic     cmd_ack,
    output logic     busy,

    // Data memory port, four-phase
    output logic     mem_req,
    output logic     mem_we,
    output addr_t    mem_addr,
    output vec_t     mem_wdata,
    input  logic     mem_ack,
    input  vec_t     mem_rdata
);

    // ------------------------------------------------------------------------
    // Internal connections
    // ------------------------------------------------------------------------
    logic  mem_start;                           // Sequencer kicks one transfer
    logic  mem_write;
    addr_t xfer_addr;
    vec_t  wr_vec;
    logic  mem_done;                            // Transfer fully back to idle
    vec_t  rd_vec;

    logic  bf_in_valid;
    vec_t  bf_in_vec;
    logic  bf_inverse;
    logic  bf_out_valid;
    vec_t  bf_out_vec;

    rlwe_block_seq i_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_req      (cmd_req),
        .cmd_op       (cmd_op),
        .cmd_src      (cmd_src),
        .cmd_dst      (cmd_dst),
        .cmd_ack      (cmd_ack),
        .busy         (busy),
        .mem_start    (mem_start),
        .mem_write    (mem_write),
        .mem_addr_o   (xfer_addr),
        .wr_vec       (wr_vec),
        .mem_done     (mem_done),
        .rd_vec       (rd_vec),
        .bf_in_valid  (bf_in_valid),
        .bf_in_vec    (bf_in_vec),
        .bf_inverse   (bf_inverse),
        .bf_out_valid (bf_out_valid),
        .bf_out_vec   (bf_out_vec)
    );

    rlwe_mem_port i_mem_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_start  (mem_start),
        .mem_write  (mem_write),
        .mem_addr_i (xfer_addr),
        .wr_vec     (wr_vec),
        .mem_done   (mem_done),
        .rd_vec     (rd_vec),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    rlwe_butterfly_pipe i_bfly (
        .clk          (clk),
        .rst_n        (rst_n),
        .bf_in_valid  (bf_in_valid),
        .bf_in_vec    (bf_in_vec),
        .bf_inverse   (bf_inverse),
        .bf_out_valid (bf_out_valid),
        .bf_out_vec   (bf_out_vec)
    );

endmodule : rlwe_exu_top

`default_nettype wire

/* src/rlwe_block_seq.sv */
/*
 * Block sequencer
 * Command handshake, idle/read/transform/write FSM, vector counter
 * and source/destination address generation
 */

`timescale 1ns/100ps
`default_nettype none

module rlwe_block_seq
    import rlwe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cmd_req,
    input  rlwe_op_e cmd_op,
    input  addr_t    cmd_src,
    input  addr_t    cmd_dst,
    output logic     cmd_ack,
    output logic     busy,
    output logic     mem_start,                   // One-cycle transfer kick
    output logic     mem_write,
    output addr_t    mem_addr_o,
    output vec_t     wr_vec,
    input  logic     mem_done,
    input  vec_t     rd_vec,
    output logic     bf_in_valid,
    output vec_t     bf_in_vec,
    output logic     bf_inverse,
    input  logic     bf_out_valid,
    input  vec_t     bf_out_vec
);

    seq_state_e state;
    vec_idx_t   idx;                              // Vector within the block
    vec_idx_t   idx_next;
    rlwe_op_e   op_q;                             // Latched command fields
    addr_t      src_q;
    addr_t      dst_q;

    logic       accept;
    logic       bf_capture;
    logic       wr_done;
    logic       last_vec;

    assign accept     = (state == SEQ_IDLE) && cmd_req;
    assign bf_capture = (state == SEQ_XFORM) && bf_out_valid;
    assign wr_done    = (state == SEQ_WRITE) && mem_done;
    assign idx_next   = idx + 1'b1;
    assign last_vec   = (idx_next == vec_idx_t'(BLOCK_VECTORS));  // Vector 63 written

    // Read data goes straight into the stage, it is held in the port
    assign bf_in_vec  = rd_vec;
    assign bf_inverse = (op_q == RLWE_INV);

    // ------------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= SEQ_IDLE;
            idx         <= '0;
            cmd_ack     <= 1'b0;
            busy        <= 1'b0;
            mem_start   <= 1'b0;
            mem_write   <= 1'b0;
            bf_in_valid <= 1'b0;
        end else begin
            mem_start   <= 1'b0;                  // Pulses by default
            bf_in_valid <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        idx       <= '0;
                        busy      <= 1'b1;
                        mem_start <= 1'b1;        // First source read
                        mem_write <= 1'b0;
                        state     <= SEQ_READ;
                    end
                end
                SEQ_READ: begin
                    if (mem_done) begin
                        bf_in_valid <= 1'b1;
                        state       <= SEQ_XFORM;
                    end
                end
                SEQ_XFORM: begin
                    if (bf_capture) begin
                        mem_start <= 1'b1;        // Destination write
                        mem_write <= 1'b1;
                        state     <= SEQ_WRITE;
                    end
                end
                SEQ_WRITE: begin
                    if (wr_done) begin
                        idx <= idx_next;
                        if (last_vec) begin
                            busy    <= 1'b0;      // Drops as ack rises
                            cmd_ack <= 1'b1;
                            state   <= SEQ_DONE;
                        end else begin
                            mem_start <= 1'b1;    // Next source read
                            mem_write <= 1'b0;
                            state     <= SEQ_READ;
                        end
                    end
                end
                SEQ_DONE: begin
                    if (!cmd_req) begin           // Host released, close handshake
                        cmd_ack <= 1'b0;
                        state   <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Command fields, addresses and write data
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= cmd_op;
            src_q      <= cmd_src;
            dst_q      <= cmd_dst;
            mem_addr_o <= cmd_src;                // Vector 0 of the source
        end
        if (bf_capture) begin
            wr_vec     <= bf_out_vec;
            mem_addr_o <= dst_q + addr_t'(idx);
        end
        if (wr_done && !last_vec) begin
            mem_addr_o <= src_q + addr_t'(idx_next);
        end
    end

endmodule : rlwe_block_seq

`default_nettype wire

/* src/rlwe_mem_port.sv */
/*
 * Data-memory master
 * Four-phase req/ack phase machine with read-data capture
 */

`timescale 1ns/100ps
`default_nettype none

module rlwe_mem_port
    import rlwe_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mem_start,
    input  logic  mem_write,
    input  addr_t mem_addr_i,
    input  vec_t  wr_vec,
    output logic  mem_done,                       // One cycle, handshake fully idle
    output vec_t  rd_vec,                         // Last read word
    output logic  mem_req,
    output logic  mem_we,
    output addr_t mem_addr,
    output vec_t  mem_wdata,
    input  logic  mem_ack,
    input  vec_t  mem_rdata
);

    typedef enum logic [1:0] {
        MP_IDLE    = 2'd0,
        MP_REQ     = 2'd1,                        // Request up, waiting for ack
        MP_RELEASE = 2'd2                         // Request down, waiting for ack low
    } mp_phase_e;

    mp_phase_e phase;

    assign mem_req = (phase == MP_REQ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase    <= MP_IDLE;
            mem_we   <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            case (phase)
                MP_IDLE: begin
                    if (mem_start) begin          // Kicks are only taken here
                        mem_we <= mem_write;
                        phase  <= MP_REQ;
                    end
                end
                MP_REQ: begin
                    if (mem_ack) phase <= MP_RELEASE;
                end
                MP_RELEASE: begin
                    if (!mem_ack) begin
                        mem_done <= 1'b1;
                        phase    <= MP_IDLE;
                    end
                end
                default: phase <= MP_IDLE;
            endcase
        end
    end

    // Address and data held stable for the whole request
    always_ff @(posedge clk) begin
        if (phase == MP_IDLE && mem_start) begin
            mem_addr  <= mem_addr_i;
            mem_wdata <= wr_vec;
        end
        if (mem_req && mem_ack && !mem_we) begin
            rd_vec <= mem_rdata;                  // Valid while ack is high
        end
    end

endmodule : rlwe_mem_port

`default_nettype wire

/* src/rlwe_butterfly_pipe.sv */
/*
 * Lane-pair modular butterfly, two register stages
 * Stage 1 computes (a+b, a-b) mod Q on pairs (0,1) and (2,3),
 * stage 2 halves every lane mod Q for the inverse direction
 */

`timescale 1ns/100ps
`default_nettype none

module rlwe_butterfly_pipe
    import rlwe_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic bf_in_valid,
    input  vec_t bf_in_vec,
    input  logic bf_inverse,
    output logic bf_out_valid,                    // bf_in_valid delayed by 2
    output vec_t bf_out_vec
);

    logic s1_valid;
    logic s1_inv;                                 // Direction travels with the data
    vec_t s1_vec;
    vec_t s1_next;
    vec_t s2_next;

    // ------------------------------------------------------------------------
    // Modular helpers, operands already below Q so 16 bits never overflow
    // ------------------------------------------------------------------------
    function automatic lane_t mod_add(input lane_t a, input lane_t b);
        lane_t sum;
        sum = a + b;
        if (sum >= lane_t'(RLWE_Q)) sum = sum - lane_t'(RLWE_Q);
        return sum;
    endfunction

    function automatic lane_t mod_sub(input lane_t a, input lane_t b);
        if (a >= b) return a - b;
        return a + lane_t'(RLWE_Q) - b;           // Wrap negative back into range
    endfunction

    function automatic lane_t mod_half(input lane_t v);
        if (v[0]) return (v + lane_t'(RLWE_Q)) >> 1;  // Odd, Q makes it even
        return v >> 1;
    endfunction

    // ------------------------------------------------------------------------
    // Stage 1 butterfly
    // ------------------------------------------------------------------------
    always_comb begin
        lane_t a;
        lane_t b;
        s1_next = '0;
        for (int p = 0; p < LANE_COUNT / 2; p++) begin
            a = bf_in_vec[(2*p)*LANE_W +: LANE_W];       // Even lane
            b = bf_in_vec[(2*p+1)*LANE_W +: LANE_W];     // Odd lane
            s1_next[(2*p)*LANE_W +: LANE_W]   = mod_add(a, b);
            s1_next[(2*p+1)*LANE_W +: LANE_W] = mod_sub(a, b);
        end
    end

    // ------------------------------------------------------------------------
    // Stage 2 optional halving
    // ------------------------------------------------------------------------
    always_comb begin
        lane_t v;
        s2_next = s1_vec;                         // Forward passes through
        for (int l = 0; l < LANE_COUNT; l++) begin
            v = s1_vec[l*LANE_W +: LANE_W];
            if (s1_inv) s2_next[l*LANE_W +: LANE_W] = mod_half(v);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            bf_out_valid <= 1'b0;
        end else begin
            s1_valid     <= bf_in_valid;
            bf_out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (bf_in_valid) begin
            s1_vec <= s1_next;
            s1_inv <= bf_inverse;
        end
        if (s1_valid) bf_out_vec <= s2_next;
    end

endmodule : rlwe_butterfly_pipe

`default_nettype wire

/* src/rlwe_pkg.sv */
/*
 * RLWE block-transform package
 * Lane, vector and address widths, modulus, block size,
 * vector typedefs, transform direction and sequencer state enums
 */

`default_nettype none

package rlwe_pkg;

    // ------------------------------------------------------------------------
    // Geometry and modulus
    // ------------------------------------------------------------------------
    localparam int LANE_W        = 16;                   // Bits per coefficient lane
    localparam int LANE_COUNT    = 4;                    // Lanes per memory word
    localparam int VEC_W         = LANE_W * LANE_COUNT;  // One memory word, 64 bits
    localparam int RLWE_Q        = 12289;                // Coefficient modulus
    localparam int BLOCK_VECTORS = 64;                   // Vectors walked per command
    localparam int ADDR_W        = 16;                   // Vector-granular address

    // ------------------------------------------------------------------------
    // Data types
    // ------------------------------------------------------------------------
    typedef logic [LANE_W-1:0] lane_t;                   // Value in 0 .. RLWE_Q-1
    typedef logic [VEC_W-1:0]  vec_t;                    // Lane 0 in the low bits
    typedef logic [ADDR_W-1:0] addr_t;

    // Wide enough to reach BLOCK_VECTORS itself
    typedef logic [$clog2(BLOCK_VECTORS+1)-1:0] vec_idx_t;

    // Transform direction carried by the command
    typedef enum logic {
        RLWE_FWD = 1'b0,                                 // Forward butterfly
        RLWE_INV = 1'b1                                  // Butterfly then halve
    } rlwe_op_e;

    // Block sequencer states
    typedef enum logic [2:0] {
        SEQ_IDLE  = 3'd0,                                // Waiting for a command
        SEQ_READ  = 3'd1,                                // Source read in flight
        SEQ_XFORM = 3'd2,                                // Vector in the butterfly stage
        SEQ_WRITE = 3'd3,                                // Destination write in flight
        SEQ_DONE  = 3'd4                                 // Ack held until req drops
    } seq_state_e;

endpackage : rlwe_pkg

`default_nettype wire
